//--- Bender.yml
package:
  name: isp_top

sources:
  - logic/axi_pkg.sv
  - logic/isp_pkg.sv
  - logic/isp_ctrl.sv
  - logic/dram_burst_port.sv
  - logic/pixel_gain.sv
  - logic/exposure_meter.sv
  - logic/exposure_cache.sv
  - logic/isp_top.sv
  - target: test
    files:
      - test/dram_model.sv
      - test/isp_top_tb.sv

//--- isp_top.f
logic/axi_pkg.sv
logic/isp_pkg.sv
logic/isp_ctrl.sv
logic/dram_burst_port.sv
logic/pixel_gain.sv
logic/exposure_meter.sv
logic/exposure_cache.sv
logic/isp_top.sv
test/dram_model.sv
test/isp_top_tb.sv

//--- logic/axi_pkg.sv
package axi_pkg;

    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 128;

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;

    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;

    // one burst covers a whole picture, 192 beats
    localparam axi_len_t   AXI_BURST_LEN  = 8'd191;
    localparam axi_size_t  AXI_SIZE_16B   = 3'b100;
    localparam axi_burst_t AXI_BURST_INCR = 2'b01;

    // ------------------------------
    // address channels
    // ------------------------------
    typedef struct packed {
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } axi_ar_t;

    // same field order as ar
    typedef struct packed {
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } axi_aw_t;

endpackage

//--- logic/dram_burst_port.sv
`timescale 1ns/1ps

module dram_burst_port
    import axi_pkg::*;
    import isp_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         xfer_start,
    input  axi_addr_t    xfer_addr,
    input  logic         beat_in_ready,
    input  beat_pixels_t beat_out,
    input  logic         beat_out_valid,
    output logic         beat_in_valid,
    output beat_pixels_t beat_in,
    output logic         beat_out_ready,
    output logic         xfer_done,

    output axi_ar_t      ar,
    output logic         arvalid,
    input  logic         arready,

    input  axi_data_t    rdata,
    input  logic         rlast,
    input  logic         rvalid,
    output logic         rready,

    output axi_aw_t      aw,
    output logic         awvalid,
    input  logic         awready,

    output axi_data_t    wdata,
    output logic         wlast,
    output logic         wvalid,
    input  logic         wready,

    input  logic         bvalid,
    output logic         bready
);

    axi_addr_t                        addr_q;
    logic                             rd_active;
    logic [$clog2(BEATS_PER_PIC)-1:0] wr_cnt;

    always_ff @(posedge clk) begin
        if (xfer_start) begin
            addr_q <= xfer_addr;
        end
    end

    // ------------------------------
    // address channels
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
            awvalid <= 1'b0;
        end else if (xfer_start) begin
            arvalid <= 1'b1;
            awvalid <= 1'b1;
        end else begin
            if (arvalid && arready) arvalid <= 1'b0;
            if (awvalid && awready) awvalid <= 1'b0;
        end
    end

    assign ar = '{addr: addr_q, len: AXI_BURST_LEN, size: AXI_SIZE_16B, burst: AXI_BURST_INCR};
    assign aw = '{addr: addr_q, len: AXI_BURST_LEN, size: AXI_SIZE_16B, burst: AXI_BURST_INCR};

    // ------------------------------
    // read data into the gain buffer
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_active <= 1'b0;
        end else if (xfer_start) begin
            rd_active <= 1'b1;
        end else if (rvalid && rready && rlast) begin
            rd_active <= 1'b0;
        end
    end

    // stalls whenever the buffer still holds a beat
    assign rready        = rd_active && beat_in_ready;
    assign beat_in_valid = rvalid && rready;
    assign beat_in       = rdata;

    // ------------------------------
    // write data and response
    // ------------------------------
    assign wvalid         = beat_out_valid;
    assign wdata          = beat_out;
    assign beat_out_ready = wready;
    assign wlast          = (wr_cnt == AXI_BURST_LEN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt <= '0;
        end else if (xfer_start) begin
            wr_cnt <= '0;
        end else if (wvalid && wready) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bready <= 1'b0;
        end else if (wvalid && wready && wlast) begin
            bready <= 1'b1;
        end else if (bvalid && bready) begin
            bready <= 1'b0;
        end
    end

    assign xfer_done = bvalid && bready;

endmodule

//--- logic/exposure_cache.sv
`timescale 1ns/1ps

module exposure_cache
    import isp_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  pic_no_t      pic_no,
    input  logic         wr,
    input  cache_entry_t wdata,
    output cache_entry_t entry
);

    // level 0 with all_zero clear means not measured yet
    cache_entry_t entries [PIC_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PIC_COUNT; i++) begin
                entries[i] <= '0;
            end
        end else if (wr) begin
            entries[pic_no] <= wdata;
        end
    end

    assign entry = entries[pic_no];

endmodule

//--- logic/exposure_meter.sv
`timescale 1ns/1ps

module exposure_meter
    import isp_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         clear,
    input  logic         beat_valid,
    input  beat_pixels_t beat,
    output pixel_t       level,
    output logic         all_zero
);

    logic [EXP_TOTAL_W-1:0]           total;
    logic [EXP_TOTAL_W-1:0]           beat_sum;
    logic [$clog2(BEATS_PER_PIC)-1:0] beat_cnt;
    logic                             sample;
    logic                             green;

    // buffer loads on the fill edge, its contents are read a cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample <= 1'b0;
        end else begin
            sample <= beat_valid && !clear;
        end
    end

    // green plane weighs twice red and blue
    assign green = (beat_cnt >= BEATS_PER_PLANE) && (beat_cnt < 2 * BEATS_PER_PLANE);

    always_comb begin
        beat_sum = '0;
        for (int i = 0; i < PIXELS_PER_BEAT; i++) begin
            if (green) begin
                beat_sum = beat_sum + EXP_TOTAL_W'(beat[i] >> 1);
            end else begin
                beat_sum = beat_sum + EXP_TOTAL_W'(beat[i] >> 2);
            end
        end
    end

    // ------------------------------
    // accumulation
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            total    <= '0;
            beat_cnt <= '0;
            all_zero <= 1'b1;
        end else if (clear) begin
            total    <= '0;
            beat_cnt <= '0;
            all_zero <= 1'b1;
        end else if (sample) begin
            total    <= total + beat_sum;
            beat_cnt <= beat_cnt + 1'b1;
            all_zero <= all_zero && (beat == '0);
        end
    end

    assign level = total[EXP_SHIFT +: 8];

endmodule

//--- logic/isp_ctrl.sv
`timescale 1ns/1ps

module isp_ctrl
    import axi_pkg::*;
    import isp_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    input  pic_no_t      in_pic_no,
    input  ratio_e       in_ratio_mode,
    input  cache_entry_t entry,
    input  logic         xfer_done,
    input  pixel_t       exp_level,
    input  logic         exp_all_zero,
    output pic_no_t      pic_no,
    output ratio_e       ratio,
    output logic         xfer_start,
    output axi_addr_t    xfer_addr,
    output logic         meter_clear,
    output logic         cache_wr,
    output cache_entry_t cache_wdata,
    output logic         out_valid,
    output pixel_t       out_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_XFER,
        ST_RESPOND
    } state_e;

    state_e state;
    state_e state_next;
    logic   hit;
    pixel_t hit_data;

    // request capture
    always_ff @(posedge clk) begin
        if (in_valid && state == ST_IDLE) begin
            pic_no <= in_pic_no;
            ratio  <= in_ratio_mode;
        end
    end

    // ------------------------------
    // cache decision
    // ------------------------------
    always_comb begin
        hit      = 1'b0;
        hit_data = '0;
        if (entry.all_zero) begin
            hit = 1'b1;
        end else if (ratio == RATIO_UNITY && entry.level != '0) begin
            hit      = 1'b1;
            hit_data = entry.level;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE:    if (in_valid) state_next = ST_LOOKUP;
            ST_LOOKUP:  state_next = hit ? ST_RESPOND : ST_XFER;
            ST_XFER:    if (xfer_done) state_next = ST_RESPOND;
            ST_RESPOND: state_next = ST_IDLE;
            default:    state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // miss path
    assign xfer_start  = (state == ST_LOOKUP) && !hit;
    assign meter_clear = xfer_start;
    assign xfer_addr   = PIC_BASE_ADDR + axi_addr_t'(pic_no) * PIC_STRIDE;

    assign cache_wr    = (state == ST_XFER) && xfer_done;
    assign cache_wdata = '{all_zero: exp_all_zero, level: exp_level};

    // ------------------------------
    // response
    // ------------------------------
    always_ff @(posedge clk) begin
        if (state == ST_LOOKUP && hit) begin
            out_data <= hit_data;
        end else if (cache_wr) begin
            out_data <= exp_level;
        end
    end

    assign out_valid = (state == ST_RESPOND);

endmodule

//--- logic/isp_pkg.sv
package isp_pkg;

    // ------------------------------
    // pixel data
    // ------------------------------
    localparam int PIXELS_PER_BEAT = 16;

    typedef logic [7:0] pixel_t;

    // pixel 0 sits in the low byte of the beat
    typedef pixel_t [PIXELS_PER_BEAT-1:0] beat_pixels_t;

    typedef enum logic [1:0] {
        RATIO_QUARTER = 2'd0,
        RATIO_HALF    = 2'd1,
        RATIO_UNITY   = 2'd2,
        RATIO_DOUBLE  = 2'd3
    } ratio_e;

    // ------------------------------
    // pictures and results
    // ------------------------------
    localparam int PIC_COUNT = 16;

    typedef logic [3:0] pic_no_t;

    typedef struct packed {
        logic   all_zero;
        pixel_t level;
    } cache_entry_t;

    // dram map, red plane then green then blue
    localparam logic [31:0] PIC_BASE_ADDR   = 32'h0001_0000;
    localparam logic [31:0] PIC_STRIDE      = 32'h0000_0C00;
    localparam int          BEATS_PER_PIC   = 192;
    localparam int          BEATS_PER_PLANE = 64;

    // total is 18 bits, the top byte is the result
    localparam int EXP_TOTAL_W = 18;
    localparam int EXP_SHIFT   = 10;

endpackage

//--- logic/isp_top.sv
`timescale 1ns/1ps

module isp_top
    import axi_pkg::*;
    import isp_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  pic_no_t   in_pic_no,
    input  ratio_e    in_ratio_mode,
    output logic      out_valid,
    output pixel_t    out_data,

    output axi_ar_t   ar,
    output logic      arvalid,
    input  logic      arready,

    input  axi_data_t rdata,
    input  logic      rlast,
    input  logic      rvalid,
    output logic      rready,

    output axi_aw_t   aw,
    output logic      awvalid,
    input  logic      awready,

    output axi_data_t wdata,
    output logic      wlast,
    output logic      wvalid,
    input  logic      wready,

    input  logic      bvalid,
    output logic      bready
);

    pic_no_t      pic_no;
    ratio_e       ratio;
    cache_entry_t entry;
    cache_entry_t cache_wdata;
    logic         cache_wr;
    logic         xfer_start;
    axi_addr_t    xfer_addr;
    logic         xfer_done;
    logic         meter_clear;
    pixel_t       exp_level;
    logic         exp_all_zero;

    logic         beat_in_valid;
    logic         beat_in_ready;
    beat_pixels_t beat_in;
    beat_pixels_t beat_out;
    logic         beat_out_valid;
    logic         beat_out_ready;

    isp_ctrl isp_ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_pic_no    (in_pic_no),
        .in_ratio_mode(in_ratio_mode),
        .entry        (entry),
        .xfer_done    (xfer_done),
        .exp_level    (exp_level),
        .exp_all_zero (exp_all_zero),
        .pic_no       (pic_no),
        .ratio        (ratio),
        .xfer_start   (xfer_start),
        .xfer_addr    (xfer_addr),
        .meter_clear  (meter_clear),
        .cache_wr     (cache_wr),
        .cache_wdata  (cache_wdata),
        .out_valid    (out_valid),
        .out_data     (out_data)
    );

    dram_burst_port dram_burst_port_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .xfer_start    (xfer_start),
        .xfer_addr     (xfer_addr),
        .beat_in_ready (beat_in_ready),
        .beat_out      (beat_out),
        .beat_out_valid(beat_out_valid),
        .beat_in_valid (beat_in_valid),
        .beat_in       (beat_in),
        .beat_out_ready(beat_out_ready),
        .xfer_done     (xfer_done),
        .ar            (ar),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rlast         (rlast),
        .rvalid        (rvalid),
        .rready        (rready),
        .aw            (aw),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wlast         (wlast),
        .wvalid        (wvalid),
        .wready        (wready),
        .bvalid        (bvalid),
        .bready        (bready)
    );

    pixel_gain pixel_gain_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .ratio         (ratio),
        .beat_in_valid (beat_in_valid),
        .beat_in       (beat_in),
        .beat_out_ready(beat_out_ready),
        .beat_in_ready (beat_in_ready),
        .beat_out      (beat_out),
        .beat_out_valid(beat_out_valid)
    );

    // meter watches the buffer fill and reads the buffered beat
    exposure_meter exposure_meter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (meter_clear),
        .beat_valid(beat_in_valid),
        .beat      (beat_out),
        .level     (exp_level),
        .all_zero  (exp_all_zero)
    );

    exposure_cache exposure_cache_i (
        .clk   (clk),
        .rst_n (rst_n),
        .pic_no(pic_no),
        .wr    (cache_wr),
        .wdata (cache_wdata),
        .entry (entry)
    );

endmodule

//--- logic/pixel_gain.sv
`timescale 1ns/1ps

module pixel_gain
    import isp_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  ratio_e       ratio,
    input  logic         beat_in_valid,
    input  beat_pixels_t beat_in,
    input  logic         beat_out_ready,
    output logic         beat_in_ready,
    output beat_pixels_t beat_out,
    output logic         beat_out_valid
);

    beat_pixels_t scaled;
    logic         full;

    function automatic pixel_t scale_pixel(pixel_t p, ratio_e r);
        case (r)
            RATIO_QUARTER: return p >> 2;
            RATIO_HALF:    return p >> 1;
            // double saturates once the top bit is set
            RATIO_DOUBLE:  return p[7] ? 8'hFF : pixel_t'(p << 1);
            default:       return p;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < PIXELS_PER_BEAT; i++) begin
            scaled[i] = scale_pixel(beat_in[i], ratio);
        end
    end

    // one-beat buffer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (beat_in_valid) begin
            full <= 1'b1;
        end else if (beat_out_valid && beat_out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_in_valid) begin
            beat_out <= scaled;
        end
    end

    assign beat_in_ready  = !full;
    assign beat_out_valid = full;

endmodule

//--- test/dram_model.sv
`timescale 1ns/1ps

module dram_model
    import axi_pkg::*;
    import isp_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  axi_ar_t   ar,
    input  logic      arvalid,
    input  logic      arready,
    output axi_data_t rdata,
    output logic      rlast,
    output logic      rvalid,
    input  logic      rready,
    input  axi_aw_t   aw,
    input  logic      awvalid,
    output logic      awready,
    input  axi_data_t wdata,
    input  logic      wlast,
    input  logic      wvalid,
    input  logic      wready,
    output logic      bvalid,
    input  logic      bready,
    output int        protocol_errors
);

    localparam int MEM_BEATS = PIC_COUNT * BEATS_PER_PIC;

    // one entry per 16-byte beat, picture 0 at index 0
    axi_data_t mem [MEM_BEATS];
    logic      rd_busy;
    int        rd_base;
    int        rd_cnt;
    int        rd_len;
    int        wr_base;
    int        wr_cnt;
    int        wr_len;

    function automatic logic burst_ok(axi_ar_t req);
        return req.addr >= PIC_BASE_ADDR && req.addr < PIC_BASE_ADDR + PIC_COUNT * PIC_STRIDE
            && req.addr[3:0] == 4'h0 && req.len == 8'd191 && req.size == 3'd4
            && req.burst == 2'd1;
    endfunction

    function automatic int beat_index(axi_addr_t addr);
        return int'((addr - PIC_BASE_ADDR) >> 4);
    endfunction

    assign awready = 1'b1;
    assign rvalid  = rd_busy;
    assign rlast   = rd_busy && (rd_cnt == rd_len);
    assign rdata   = rd_busy ? mem[rd_base + rd_cnt] : '0;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_busy         <= 1'b0;
            rd_base         <= 0;
            rd_cnt          <= 0;
            rd_len          <= 0;
            wr_base         <= 0;
            wr_cnt          <= 0;
            wr_len          <= 0;
            bvalid          <= 1'b0;
            protocol_errors = 0;
        end else begin
            // ------------------------------
            // read side
            // ------------------------------
            if (arvalid && arready) begin
                rd_base <= burst_ok(ar) ? beat_index(ar.addr) : 0;
                rd_len  <= ar.len;
                rd_cnt  <= 0;
                rd_busy <= 1'b1;
                if (!burst_ok(ar)) begin
                    $display("Error %0t: bad read burst at %h", $time, ar.addr);
                    protocol_errors++;
                end
            end else if (rvalid && rready) begin
                rd_cnt <= rd_cnt + 1;
                if (rlast) begin
                    rd_busy <= 1'b0;
                end
            end

            // ------------------------------
            // write side
            // ------------------------------
            if (awvalid && awready) begin
                wr_base <= burst_ok(axi_ar_t'(aw)) ? beat_index(aw.addr) : 0;
                wr_len  <= aw.len;
                wr_cnt  <= 0;
                if (!burst_ok(axi_ar_t'(aw))) begin
                    $display("Error %0t: bad write burst at %h", $time, aw.addr);
                    protocol_errors++;
                end
            end else if (wvalid && wready) begin
                mem[wr_base + wr_cnt] <= wdata;
                wr_cnt <= wr_cnt + 1;
                if (wlast != (wr_cnt == wr_len)) begin
                    $display("Error %0t: wlast is %b on write beat %0d", $time, wlast, wr_cnt);
                    protocol_errors++;
                end
                if (wlast) begin
                    bvalid <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

//--- test/isp_top_tb.sv
`timescale 1ns/1ps

module isp_top_tb
    import axi_pkg::*;
    import isp_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 5000;
    localparam int TRACE_WORDS    = 256;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    pic_no_t   in_pic_no;
    ratio_e    in_ratio_mode;
    logic      out_valid;
    pixel_t    out_data;
    axi_ar_t   ar;
    logic      arvalid;
    logic      arready;
    axi_data_t rdata;
    logic      rlast;
    logic      rvalid;
    logic      rready;
    axi_aw_t   aw;
    logic      awvalid;
    logic      awready;
    axi_data_t wdata;
    logic      wlast;
    logic      wvalid;
    logic      wready;
    logic      bvalid;
    logic      bready;
    int        protocol_errors;

    logic [7:0]  trace [TRACE_WORDS];
    // what each picture should hold and what the cache should know
    pixel_t      pic_value [PIC_COUNT];
    logic        known_zero [PIC_COUNT];
    pixel_t      known_level [PIC_COUNT];
    logic [31:0] rng;
    int          value_errors;
    int          timeouts;

    isp_top isp_top_i (.*);
    dram_model dram_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // random stalls on ar and w
    always @(posedge clk) begin
        #1;
        rng     = xorshift(rng);
        arready = rng[0] | rng[1];
        wready  = rng[4:3] != 2'b00;
    end

    // ------------------------------
    // reference rules
    // ------------------------------
    function automatic pixel_t gain_value(pixel_t v, ratio_e r);
        int g;
        case (r)
            RATIO_QUARTER: g = v / 4;
            RATIO_HALF:    g = v / 2;
            RATIO_DOUBLE:  g = (v * 2 > 255) ? 255 : v * 2;
            default:       g = v;
        endcase
        return pixel_t'(g);
    endfunction

    // green weighs half a pixel and red and blue a quarter
    // 1024 pixels per plane cancel the shift by 10
    function automatic pixel_t expected_level(pixel_t v);
        return pixel_t'((v / 4) + (v / 2) + (v / 4));
    endfunction

    task automatic check_memory();
        int bad;
        for (int p = 0; p < PIC_COUNT; p++) begin
            bad = 0;
            for (int b = 0; b < BEATS_PER_PIC; b++) begin
                if (dram_i.mem[p * BEATS_PER_PIC + b] !== {16{pic_value[p]}}) bad++;
            end
            if (bad != 0) begin
                $display("Error %0t: picture %0d has %0d beats not equal to %h",
                         $time, p, bad, pic_value[p]);
                value_errors++;
            end
        end
    endtask

    task automatic run_request(input pic_no_t p, input ratio_e r, input pixel_t expected);
        logic hit;
        logic saw_ar;
        int   cycles;
        hit    = known_zero[p] || (r == RATIO_UNITY && known_level[p] != 8'd0);
        saw_ar = 1'b0;
        cycles = 0;
        @(posedge clk);
        #1;
        in_valid      = 1'b1;
        in_pic_no     = p;
        in_ratio_mode = r;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        while (!out_valid && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (arvalid) saw_ar = 1'b1;
        end
        if (!out_valid) begin
            $display("out_valid did not arrive within %0d cycles for picture %0d",
                     TIMEOUT_CYCLES, p);
            timeouts++;
        end else begin
            if (out_data !== expected) begin
                $display("Error %0t: picture %0d ratio %0d returned %h, expected %h",
                         $time, p, r, out_data, expected);
                value_errors++;
            end
            if (hit && (cycles != 2 || saw_ar)) begin
                $display("Error %0t: cached answer for picture %0d took %0d cycles, ar seen %b",
                         $time, p, cycles, saw_ar);
                value_errors++;
            end
            if (!hit && !saw_ar) begin
                $display("Error %0t: miss on picture %0d issued no read burst", $time, p);
                value_errors++;
            end
            if (!hit) begin
                pic_value[p]   = gain_value(pic_value[p], r);
                known_zero[p]  = (pic_value[p] == 8'd0);
                known_level[p] = expected_level(pic_value[p]);
            end
            check_memory();
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        int idx;
        int requests;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_pic_no     = '0;
        in_ratio_mode = RATIO_UNITY;
        arready       = 1'b0;
        wready        = 1'b0;
        rng           = 32'd82916;
        value_errors  = 0;
        timeouts      = 0;
        requests      = 0;
        for (int i = 0; i < TRACE_WORDS; i++) begin
            trace[i] = 8'hff;
        end
        $readmemh("test/isp_trace.txt", trace);
        for (int p = 0; p < PIC_COUNT; p++) begin
            pic_value[p]   = trace[p];
            known_zero[p]  = 1'b0;
            known_level[p] = 8'd0;
            for (int b = 0; b < BEATS_PER_PIC; b++) begin
                dram_i.mem[p * BEATS_PER_PIC + b] = {16{trace[p]}};
            end
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (out_valid || arvalid || awvalid || rready || wvalid || bready) begin
            $display("Error %0t: handshake outputs not low after reset", $time);
            value_errors++;
        end

        // requests follow the fill bytes and ff ends the list
        idx = PIC_COUNT;
        while (idx + 2 < TRACE_WORDS && trace[idx] != 8'hff && timeouts == 0) begin
            run_request(pic_no_t'(trace[idx]), ratio_e'(trace[idx + 1][1:0]), trace[idx + 2]);
            requests++;
            idx += 3;
        end
        if (requests == 0) begin
            $display("no requests were found in test/isp_trace.txt");
            value_errors++;
        end

        $display("errors %0d value, %0d protocol, %0d timeout",
                 value_errors, protocol_errors, timeouts);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- test/isp_trace.txt
// first data line gives the fill byte of pictures 0 to 15
// then one request per line with picture, ratio code 0 to 3 and expected out_data
40 00 90 21 c8 07 11 22 33 44 55 66 77 88 99 aa
0 2 40
0 2 40
2 3 fd
3 0 08
4 1 64
1 1 00
1 3 00
4 3 c8
4 2 c8
0 3 80
5 2 05
ff
